// ==== common/mpad_cfg.svh ====
// ==================================================
// Mirror-padding engine configuration
// Bus widths, coordinate width and fixed AXI codes
// ==================================================
`ifndef MPAD_CFG_SVH
`define MPAD_CFG_SVH

`define MPAD_ADDR_W     32
`define MPAD_DATA_W     32
`define MPAD_DIM_W      6
`define MPAD_ID_W       4
`define MPAD_LEN_W      4
`define MPAD_RESP_W     2
`define MPAD_STRB_W     4

`define MPAD_AXI_SIZE   3'b010  // 4 bytes per beat
`define MPAD_AXI_BURST  2'b01   // INCR
`define MPAD_WORD_BYTES 4

`endif

// ==== common/axi_pkg.sv ====
// ==================================================
// AXI channel payloads
// Address, write data and read data beats as packed structs
// ==================================================
`include "mpad_cfg.svh"

package axi_pkg;

    // Read address request
    typedef struct packed {
        logic [`MPAD_ID_W-1:0]   id;
        logic [`MPAD_ADDR_W-1:0] addr;
        logic [`MPAD_LEN_W-1:0]  len;    // Beats minus one
        logic [2:0]              size;
        logic [1:0]              burst;
    } axi_ar_t;

    // Write address carries the same fields
    typedef axi_ar_t axi_aw_t;

    // Write data beat
    typedef struct packed {
        logic [`MPAD_ID_W-1:0]   id;
        logic [`MPAD_DATA_W-1:0] data;
        logic [`MPAD_STRB_W-1:0] strb;
        logic                    last;
    } axi_w_t;

    // Read data beat
    typedef struct packed {
        logic [`MPAD_ID_W-1:0]   id;
        logic [`MPAD_DATA_W-1:0] data;
        logic [`MPAD_RESP_W-1:0] resp;
        logic                    last;
    } axi_r_t;

endpackage

// ==== common/mpad_pkg.sv ====
// ==================================================
// Padding engine types
// Job configuration, coordinates and internal words
// ==================================================
`include "mpad_cfg.svh"

package mpad_pkg;

    typedef logic [`MPAD_DIM_W-1:0]  dim_t;   // Row, column or width
    typedef logic [`MPAD_DATA_W-1:0] word_t;

    // Job latched at start
    typedef struct packed {
        logic [`MPAD_ADDR_W-1:0] src_addr;
        logic [`MPAD_ADDR_W-1:0] dst_addr;
        dim_t                    width;
    } pad_cfg_t;

    // One destination word
    typedef struct packed {
        logic [`MPAD_ADDR_W-1:0] addr;
        logic                    last;    // Final word of the padded matrix
    } dst_slot_t;

endpackage

// ==== read_engine/mpad_read_engine.sv ====
// ==================================================
// Read engine
// Walks the padded raster, mirrors each coordinate into
// the source and fetches one word per AXI read
// ==================================================
`timescale 1ns/1ps
`include "mpad_cfg.svh"

module mpad_read_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  mpad_pkg::pad_cfg_t cfg_i,
    output axi_pkg::axi_ar_t   ar_o,
    output logic               arvalid_o,
    input  logic               arready_i,
    input  axi_pkg::axi_r_t    r_i,
    input  logic               rvalid_i,
    output logic               rready_o,
    output mpad_pkg::word_t    rd_word_o,
    output logic               rd_valid_o,
    input  logic               rd_take_i
);
    import mpad_pkg::*;

    logic                    busy_q;
    logic [`MPAD_ADDR_W-1:0] src_base_q;
    dim_t                    width_q;
    dim_t                    row_q;
    dim_t                    col_q;
    logic                    issued_all_q;
    logic                    arvalid_q;
    logic [`MPAD_ADDR_W-1:0] araddr_q;
    logic                    pend_q;          // Read outstanding
    word_t                   hold_q;
    logic                    hold_valid_q;
    logic                    ar_fire;
    logic                    r_fire;
    logic                    issue;
    logic                    finished;

    // Padded index to 0-based source index
    function automatic dim_t mirror(input dim_t o, input dim_t w);
        if (o == '0)
            return dim_t'(1);                 // Source row 2
        else if (o == w + dim_t'(1))
            return w - dim_t'(2);             // Source row width-1
        else
            return o - dim_t'(1);
    endfunction

    function automatic logic [`MPAD_ADDR_W-1:0] src_word_addr(
        input logic [`MPAD_ADDR_W-1:0] base,
        input dim_t                    w,
        input dim_t                    r,
        input dim_t                    c
    );
        logic [`MPAD_ADDR_W-1:0] idx;
        idx = `MPAD_ADDR_W'(mirror(r, w)) * `MPAD_ADDR_W'(w) + `MPAD_ADDR_W'(mirror(c, w));
        return base + idx * `MPAD_WORD_BYTES;
    endfunction

    assign ar_fire  = arvalid_q & arready_i;
    assign r_fire   = rvalid_i & rready_o;
    assign rready_o = pend_q & ~hold_valid_q;  // Wait for a free holding register
    assign issue    = busy_q & ~arvalid_q & ~pend_q & ~issued_all_q;
    assign finished = issued_all_q & ~arvalid_q & ~pend_q & ~hold_valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q       <= 1'b0;
            arvalid_q    <= 1'b0;
            pend_q       <= 1'b0;
            hold_valid_q <= 1'b0;
            issued_all_q <= 1'b0;
            row_q        <= '0;
            col_q        <= '0;
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q       <= 1'b1;
                arvalid_q    <= 1'b1;           // Corner (0,0) goes out at once
                issued_all_q <= 1'b0;
                row_q        <= '0;
                col_q        <= dim_t'(1);
            end
        end else begin
            if (ar_fire) begin
                arvalid_q <= 1'b0;
                pend_q    <= 1'b1;
            end
            if (r_fire) begin
                pend_q       <= 1'b0;
                hold_valid_q <= 1'b1;
            end else if (rd_take_i) begin
                hold_valid_q <= 1'b0;
            end
            if (issue) begin
                arvalid_q    <= 1'b1;
                issued_all_q <= (row_q == width_q + dim_t'(1)) && (col_q == width_q + dim_t'(1));
                if (col_q == width_q + dim_t'(1)) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
            if (finished && !start_i)
                busy_q <= 1'b0;
        end
    end

    // Job fields, request address and held word
    always_ff @(posedge clk) begin
        if (!busy_q && start_i) begin
            src_base_q <= cfg_i.src_addr;
            width_q    <= cfg_i.width;
            araddr_q   <= src_word_addr(cfg_i.src_addr, cfg_i.width, '0, '0);
        end else if (issue) begin
            araddr_q <= src_word_addr(src_base_q, width_q, row_q, col_q);
        end
        if (r_fire)
            hold_q <= r_i.data;
    end

    assign ar_o = '{id: '0, addr: araddr_q, len: '0,
                    size: `MPAD_AXI_SIZE, burst: `MPAD_AXI_BURST};
    assign arvalid_o  = arvalid_q;
    assign rd_word_o  = hold_q;
    assign rd_valid_o = hold_valid_q;

endmodule

// ==== design/mpad_dst_walker.sv ====
// ==================================================
// Destination walker
// Steps through the padded raster one word per take
// ==================================================
`timescale 1ns/1ps
`include "mpad_cfg.svh"

module mpad_dst_walker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  mpad_pkg::pad_cfg_t  cfg_i,
    output mpad_pkg::dst_slot_t dst_slot_o,
    output logic                dst_valid_o,
    input  logic                dst_take_i
);
    import mpad_pkg::*;

    logic                    busy_q;
    logic                    valid_q;
    dim_t                    width_q;
    dim_t                    row_q;
    dim_t                    col_q;
    logic [`MPAD_ADDR_W-1:0] addr_q;
    logic                    at_end;
    logic                    take;

    assign at_end      = (row_q == width_q + dim_t'(1)) && (col_q == width_q + dim_t'(1));
    assign take        = valid_q & dst_take_i;
    assign dst_slot_o  = '{addr: addr_q, last: at_end};
    assign dst_valid_o = valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            row_q   <= '0;
            col_q   <= '0;
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q  <= 1'b1;
                valid_q <= 1'b1;
                row_q   <= '0;
                col_q   <= '0;
            end
        end else begin
            if (take) begin
                if (at_end) begin
                    valid_q <= 1'b0;            // Last slot consumed
                end else if (col_q == width_q + dim_t'(1)) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
            if (!valid_q && !start_i)
                busy_q <= 1'b0;
        end
    end

    // Running address and job width
    always_ff @(posedge clk) begin
        if (!busy_q && start_i) begin
            width_q <= cfg_i.width;
            addr_q  <= cfg_i.dst_addr;
        end else if (take) begin
            addr_q <= addr_q + `MPAD_ADDR_W'(`MPAD_WORD_BYTES);
        end
    end

endmodule

// ==== write_engine/mpad_write_engine.sv ====
// ==================================================
// Write engine
// Pairs each fetched word with its destination slot,
// runs AW, W and B in turn and owns the done level
// ==================================================
`timescale 1ns/1ps
`include "mpad_cfg.svh"

module mpad_write_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  mpad_pkg::word_t     rd_word_i,
    input  logic                rd_valid_i,
    output logic                rd_take_o,
    input  mpad_pkg::dst_slot_t dst_slot_i,
    input  logic                dst_valid_i,
    output logic                dst_take_o,
    output axi_pkg::axi_aw_t    aw_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    output axi_pkg::axi_w_t     w_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o,
    output logic                done_o
);
    import mpad_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BUSY,
        WR_FIN      // Done held until start drops
    } wr_state_e;

    wr_state_e               state_q;
    logic                    awvalid_q;
    logic                    wvalid_q;
    logic                    bready_q;
    logic                    last_q;
    logic                    done_q;
    logic [`MPAD_ADDR_W-1:0] awaddr_q;
    word_t                   wdata_q;
    logic                    pend;
    logic                    launch;

    assign pend   = awvalid_q | wvalid_q | bready_q;
    assign launch = (state_q == WR_BUSY) & ~pend & rd_valid_i & dst_valid_i;

    // Both sources advance as the write starts
    assign rd_take_o  = launch;
    assign dst_take_o = launch;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= WR_IDLE;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            bready_q  <= 1'b0;
            last_q    <= 1'b0;
            done_q    <= 1'b1;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (start_i) begin
                        state_q <= WR_BUSY;
                        done_q  <= 1'b0;
                        last_q  <= 1'b0;
                    end
                end
                WR_BUSY: begin
                    if (launch) begin
                        awvalid_q <= 1'b1;
                        last_q    <= dst_slot_i.last;
                    end
                    if (awvalid_q && awready_i) begin
                        awvalid_q <= 1'b0;
                        wvalid_q  <= 1'b1;
                    end
                    if (wvalid_q && wready_i) begin
                        wvalid_q <= 1'b0;
                        bready_q <= 1'b1;
                    end
                    if (bready_q && bvalid_i) begin
                        bready_q <= 1'b0;
                        if (last_q) begin
                            state_q <= WR_FIN;
                            done_q  <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (!start_i)
                        state_q <= WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            awaddr_q <= dst_slot_i.addr;
            wdata_q  <= rd_word_i;
        end
    end

    assign aw_o = '{id: '0, addr: awaddr_q, len: '0,
                    size: `MPAD_AXI_SIZE, burst: `MPAD_AXI_BURST};
    assign w_o  = '{id: '0, data: wdata_q, strb: '1, last: 1'b1};  // Single-beat writes
    assign awvalid_o = awvalid_q;
    assign wvalid_o  = wvalid_q;
    assign bready_o  = bready_q;
    assign done_o    = done_q;

endmodule

// ==== design/mpad_top.sv ====
// ==================================================
// Mirror-padding copy engine top level
// Read engine and destination walker feed the write engine
// ==================================================
`timescale 1ns/1ps
`include "mpad_cfg.svh"

module mpad_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic [`MPAD_ADDR_W-1:0] src_addr_i,
    input  logic [`MPAD_ADDR_W-1:0] dst_addr_i,
    input  mpad_pkg::dim_t          width_i,
    output logic                    done_o,
    output axi_pkg::axi_ar_t        ar_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,
    input  axi_pkg::axi_r_t         r_i,
    input  logic                    rvalid_i,
    output logic                    rready_o,
    output axi_pkg::axi_aw_t        aw_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output axi_pkg::axi_w_t         w_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    input  logic [`MPAD_RESP_W-1:0] bresp_i,   // Accepted and ignored
    input  logic                    bvalid_i,
    output logic                    bready_o
);
    import mpad_pkg::*;

    pad_cfg_t  cfg;
    word_t     rd_word;
    logic      rd_valid;
    logic      rd_take;
    dst_slot_t dst_slot;
    logic      dst_valid;
    logic      dst_take;

    assign cfg = '{src_addr: src_addr_i, dst_addr: dst_addr_i, width: width_i};

    mpad_read_engine u_read (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .cfg_i      (cfg),
        .ar_o       (ar_o),
        .arvalid_o  (arvalid_o),
        .arready_i  (arready_i),
        .r_i        (r_i),
        .rvalid_i   (rvalid_i),
        .rready_o   (rready_o),
        .rd_word_o  (rd_word),
        .rd_valid_o (rd_valid),
        .rd_take_i  (rd_take)
    );

    mpad_dst_walker u_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .cfg_i       (cfg),
        .dst_slot_o  (dst_slot),
        .dst_valid_o (dst_valid),
        .dst_take_i  (dst_take)
    );

    mpad_write_engine u_write (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .rd_word_i   (rd_word),
        .rd_valid_i  (rd_valid),
        .rd_take_o   (rd_take),
        .dst_slot_i  (dst_slot),
        .dst_valid_i (dst_valid),
        .dst_take_o  (dst_take),
        .aw_o        (aw_o),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .w_o         (w_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o),
        .done_o      (done_o)
    );

endmodule

// ==== testbench/mpad_props.sv ====
// ==================================================
// AXI handshake and done properties
// Bound to the padding engine top level
// ==================================================
`timescale 1ns/1ps
`include "mpad_cfg.svh"

module mpad_props (
    input logic             clk,
    input logic             rst_n,
    input logic             start_i,
    input logic             done_o,
    input axi_pkg::axi_ar_t ar_o,
    input logic             arvalid_o,
    input logic             arready_i,
    input axi_pkg::axi_aw_t aw_o,
    input logic             awvalid_o,
    input logic             awready_i,
    input axi_pkg::axi_w_t  w_o,
    input logic             wvalid_o,
    input logic             wready_i,
    input logic             bready_o
);
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
        else $error("AR valid or payload changed before ready");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
        else $error("AW valid or payload changed before ready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && !wready_i |=> wvalid_o && $stable(w_o))
        else $error("W valid or payload changed before ready");

    // Done only drops in answer to a start
    done_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(done_o) |-> $past(start_i))
        else $error("done fell without start");

    aw_vs_b: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o |-> !bready_o)
        else $error("AW issued while a B response is pending");
endmodule

bind mpad_top mpad_props props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (start_i),
    .done_o    (done_o),
    .ar_o      (ar_o),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .aw_o      (aw_o),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .w_o       (w_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .bready_o  (bready_o)
);

// ==== testbench/tb_mpad.sv ====
// ==================================================
// Testbench for the mirror-padding engine
// AXI memory model, job table and padded-output checks
// ==================================================
`timescale 1ns/1ps
`include "mpad_cfg.svh"

module tb_mpad;
    import mpad_pkg::*;
    import axi_pkg::*;

    typedef logic [`MPAD_ADDR_W-1:0] addr_t;
    typedef struct packed {
        addr_t src;
        addr_t dst;
        dim_t  width;
        logic  stall;   // Random ready and valid gaps
    } job_t;

    localparam int NJOBS = 4;
    job_t jobs [NJOBS] = '{
        '{32'h0000_1000, 32'h0000_8000, 6'd2, 1'b0},
        '{32'h0000_2000, 32'h0000_9000, 6'd5, 1'b0},
        '{32'h0000_2000, 32'h0000_a000, 6'd5, 1'b1},
        '{32'h0000_3100, 32'h0000_c000, 6'd7, 1'b1}
    };

    logic clk, rst_n, start_i, done_o;
    addr_t src_addr_i, dst_addr_i;
    dim_t width_i;
    axi_ar_t ar_o;
    axi_r_t r_i;
    axi_aw_t aw_o;
    axi_w_t w_o;
    logic arvalid_o, arready_i, rvalid_i, rready_o, awvalid_o, awready_i;
    logic wvalid_o, wready_i, bvalid_i, bready_o;
    logic [1:0] bresp_i;

    integer seed = 32'hfb41;
    int mismatches = 0;
    int failures = 0;
    logic stall_en = 1'b0;
    addr_t cur_dst;
    int wr_idx = 0;      // Writes seen in this job
    int bcnt = 0;
    word_t wmem [addr_t];
    int wcnt [addr_t];

    mpad_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Source contents, spread over every address bit
    function automatic word_t pattern(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_0000;
    endfunction

    // 1-based source index for a padded index
    function automatic int src_of(input int o, input int w);
        if (o == 0)
            return 2;
        if (o == w + 1)
            return w - 1;
        return o;
    endfunction

    function automatic logic go(input logic en);
        return !en || (($random(seed) & 3) != 0);
    endfunction

    task automatic check_addr(input addr_t got, input addr_t exp, input string name);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_done(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // AXI slave, sampled mid-cycle and driven just after the edge
    initial begin
        logic ar_f, r_f, aw_f, w_f, b_f, rd_pend, b_pend, stall;
        addr_t rd_addr, aw_addr;
        rd_pend = 1'b0;
        b_pend  = 1'b0;
        stall   = 1'b0;
        rd_addr = '0;
        aw_addr = '0;
        forever begin
            @(negedge clk);
            stall = stall_en;    // Job mode, settled since the last edge
            ar_f = arvalid_o & arready_i;
            r_f  = rvalid_i & rready_o;
            aw_f = awvalid_o & awready_i;
            w_f  = wvalid_o & wready_i;
            b_f  = bvalid_i & bready_o;
            if (ar_f) begin
                check_data(word_t'(ar_o.id), '0, "arid");
                check_data(word_t'(ar_o.len), '0, "arlen");
                check_data(word_t'(ar_o.size), 32'd2, "arsize");    // 4-byte beats
                check_data(word_t'(ar_o.burst), 32'd1, "arburst");  // INCR
                rd_addr = ar_o.addr;
            end
            if (aw_f) begin
                check_addr(aw_o.addr, cur_dst + addr_t'(4 * wr_idx), "awaddr");
                check_data(word_t'(aw_o.id), '0, "awid");
                check_data(word_t'(aw_o.len), '0, "awlen");
                check_data(word_t'(aw_o.size), 32'd2, "awsize");
                check_data(word_t'(aw_o.burst), 32'd1, "awburst");
                aw_addr = aw_o.addr;
                wr_idx++;
            end
            if (w_f) begin
                check_data(word_t'(w_o.strb), 32'hf, "wstrb");
                check_done(w_o.last, 1'b1, "wlast");
                check_data(word_t'(w_o.id), '0, "wid");
                wmem[aw_addr] = w_o.data;
                wcnt[aw_addr] = wcnt.exists(aw_addr) ? wcnt[aw_addr] + 1 : 1;
            end
            if (b_f)
                bcnt++;          // Counted before the edge that completes it
            @(posedge clk);
            #1;
            if (!rst_n) begin
                rd_pend = 1'b0;
                b_pend  = 1'b0;
                rvalid_i = 1'b0;
                bvalid_i = 1'b0;
            end else begin
                if (ar_f)
                    rd_pend = 1'b1;
                if (r_f)
                    rvalid_i = 1'b0;
                if (rd_pend && !rvalid_i && go(stall)) begin
                    r_i      = '{id: '0, data: pattern(rd_addr), resp: '0, last: 1'b1};
                    rvalid_i = 1'b1;
                    rd_pend  = 1'b0;
                end
                if (w_f)
                    b_pend = 1'b1;
                if (b_f)
                    bvalid_i = 1'b0;
                if (b_pend && !bvalid_i && go(stall)) begin
                    bvalid_i = 1'b1;
                    b_pend   = 1'b0;
                end
            end
            arready_i = go(stall);
            awready_i = go(stall);
            wready_i  = go(stall);
        end
    end

    task automatic wait_done(input logic level, input int limit);
        int n;
        n = 0;
        while (done_o !== level) begin
            if (n == limit) begin
                $display("Timeout at %0t waiting for done to reach %b", $time, level);
                failures++;
                $display("Mismatches: %0d, other failures: %0d", mismatches, failures);
                $display("Done: errors found");
                $finish;
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic run_job(input job_t j);
        int w, n;
        addr_t sa, da;
        w = int'(j.width);
        n = (w + 2) * (w + 2);
        wmem.delete();
        wcnt.delete();
        wr_idx   = 0;
        bcnt     = 0;
        cur_dst  = j.dst;
        stall_en = j.stall;
        src_addr_i = j.src;
        dst_addr_i = j.dst;
        width_i    = j.width;
        start_i    = 1'b1;
        @(posedge clk);
        #1;
        check_done(done_o, 1'b0, "done_o after start");
        wait_done(1'b1, 40 * n + 200);
        check_data(word_t'(bcnt), word_t'(n), "B responses before done");
        start_i = 1'b0;
        for (int r = 0; r < w + 2; r++) begin
            for (int c = 0; c < w + 2; c++) begin
                da = j.dst + addr_t'(4 * (r * (w + 2) + c));
                sa = j.src + addr_t'(4 * ((src_of(r, w) - 1) * w + src_of(c, w) - 1));
                if (!wcnt.exists(da)) begin
                    $display("No write reached address %h (row %0d col %0d)", da, r, c);
                    failures++;
                end else begin
                    check_data(wmem[da], pattern(sa), "written word");
                    check_data(word_t'(wcnt[da]), 32'd1, "writes per address");
                end
            end
        end
        check_data(word_t'(wcnt.num()), word_t'(n), "addresses written");
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n = 1'b0;
        start_i = 1'b0;
        src_addr_i = '0;
        dst_addr_i = '0;
        width_i = '0;
        arready_i = 1'b0;
        awready_i = 1'b0;
        wready_i = 1'b0;
        rvalid_i = 1'b0;
        bvalid_i = 1'b0;
        bresp_i = 2'b00;
        r_i = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_done(done_o, 1'b1, "done_o after reset");
        check_done(arvalid_o | awvalid_o | wvalid_o, 1'b0, "valids after reset");
        check_done(rready_o | bready_o, 1'b0, "readies after reset");
        for (int i = 0; i < NJOBS; i++)
            run_job(jobs[i]);
        $display("Mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end
endmodule

// ==== build.f ====
+incdir+common
common/axi_pkg.sv
common/mpad_pkg.sv
read_engine/mpad_read_engine.sv
design/mpad_dst_walker.sv
write_engine/mpad_write_engine.sv
design/mpad_top.sv
testbench/mpad_props.sv
testbench/tb_mpad.sv

// ==== Makefile ====
# Verilator build and run for the mirror-padding engine

TOP := tb_mpad

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Done: no errors"

lint:
	verilator --lint-only --assert --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
